// File: common/cpu_pkg.sv
package cpu_pkg;

  //////////////////////////////////////////////////////////////////////
  // instruction format
  //////////////////////////////////////////////////////////////////////

  localparam int inst_width     = 32;
  localparam int reg_addr_width = 5;
  localparam int imm_width      = 16;

  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int rs_msb     = 25;
  localparam int rs_lsb     = 21;
  localparam int rt_msb     = 20;
  localparam int rt_lsb     = 16;
  localparam int rd_msb     = 15;
  localparam int rd_lsb     = 11;
  localparam int imm_msb    = 15;
  localparam int imm_lsb    = 0;

  //////////////////////////////////////////////////////////////////////
  // opcodes
  //////////////////////////////////////////////////////////////////////

  // op_nop stays at zero so a cleared instruction word decodes as a nop
  typedef enum logic [5:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_slt  = 6'd5,
    op_addi = 6'd6,
    op_lw   = 6'd7,
    op_sw   = 6'd8,
    op_beq  = 6'd9,
    op_jmp  = 6'd10
  } opcode_t;

  // operand source in execute
  typedef enum logic [1:0] {
    fwd_none   = 2'd0,
    fwd_ex_mem = 2'd1,
    fwd_mem_wb = 2'd2
  } fwd_sel_t;

endpackage

// File: execute/alu.sv
`timescale 1ns/1ps

module alu #(
  parameter int data_width = 32
) (
  input  cpu_pkg::opcode_t      op,
  input  logic [data_width-1:0] a,
  input  logic [data_width-1:0] b,
  output logic [data_width-1:0] result
);

  always_comb begin
    case (op)
      cpu_pkg::op_add, cpu_pkg::op_addi, cpu_pkg::op_lw, cpu_pkg::op_sw: begin
        result = a + b;
      end
      // beq compares by subtracting
      cpu_pkg::op_sub, cpu_pkg::op_beq: begin
        result = a - b;
      end
      cpu_pkg::op_and: begin
        result = a & b;
      end
      cpu_pkg::op_or: begin
        result = a | b;
      end
      cpu_pkg::op_slt: begin
        result = ($signed(a) < $signed(b)) ? data_width'(1) : '0;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// File: execute/execute_unit.sv
`timescale 1ns/1ps

module execute_unit #(
  parameter int data_width = 32,
  parameter int addr_width = 16
) (
  input  logic                               clk,
  input  logic                               reset,
  input  cpu_pkg::opcode_t                   ex_op,
  input  logic [data_width-1:0]              ex_a,
  input  logic [data_width-1:0]              ex_b,
  input  logic [cpu_pkg::imm_width-1:0]      ex_imm,
  input  logic [cpu_pkg::reg_addr_width-1:0] ex_dst,
  input  logic                               ex_reg_write,
  input  cpu_pkg::fwd_sel_t                  fwd_a,
  input  cpu_pkg::fwd_sel_t                  fwd_b,
  input  logic [data_width-1:0]              wb_value,
  output logic                               branch_taken,
  output logic [addr_width-1:0]              branch_target,
  output cpu_pkg::opcode_t                   mem_op,
  output logic [data_width-1:0]              mem_alu,
  output logic [data_width-1:0]              mem_store_data,
  output logic [cpu_pkg::reg_addr_width-1:0] mem_dst,
  output logic                               mem_reg_write
);

  logic [data_width-1:0] op_a;
  logic [data_width-1:0] op_b;
  logic [data_width-1:0] alu_b;
  logic [data_width-1:0] alu_result;
  logic                  use_imm;

  // forwarding muxes
  always_comb begin
    case (fwd_a)
      cpu_pkg::fwd_ex_mem: op_a = mem_alu;
      cpu_pkg::fwd_mem_wb: op_a = wb_value;
      default:             op_a = ex_a;
    endcase
    case (fwd_b)
      cpu_pkg::fwd_ex_mem: op_b = mem_alu;
      cpu_pkg::fwd_mem_wb: op_b = wb_value;
      default:             op_b = ex_b;
    endcase
  end

  assign use_imm = (ex_op == cpu_pkg::op_addi) || (ex_op == cpu_pkg::op_lw) ||
                   (ex_op == cpu_pkg::op_sw);
  assign alu_b   = use_imm ? data_width'(ex_imm) : op_b;

  alu #(.data_width(data_width)) alu_inst (
    .op(ex_op),
    .a(op_a),
    .b(alu_b),
    .result(alu_result)
  );

  // absolute target taken from imm
  assign branch_taken  = (ex_op == cpu_pkg::op_jmp) ||
                         (ex_op == cpu_pkg::op_beq && alu_result == '0);
  assign branch_target = addr_width'(ex_imm);

  //////////////////////////////////////////////////////////////////////
  // ex/mem
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_op        <= cpu_pkg::op_nop;
      mem_dst       <= '0;
      mem_reg_write <= 1'b0;
    end else begin
      mem_op        <= ex_op;
      mem_dst       <= ex_reg_write ? ex_dst : '0;
      mem_reg_write <= ex_reg_write;
    end
    mem_alu        <= alu_result;
    mem_store_data <= op_b;
  end

endmodule

// File: hdl/pipeline_control.sv
`timescale 1ns/1ps

module pipeline_control (
  input  logic [cpu_pkg::reg_addr_width-1:0] id_rs,
  input  logic [cpu_pkg::reg_addr_width-1:0] id_rt,
  input  logic [cpu_pkg::reg_addr_width-1:0] ex_rs,
  input  logic [cpu_pkg::reg_addr_width-1:0] ex_rt,
  input  logic [cpu_pkg::reg_addr_width-1:0] ex_dst,
  input  logic                               ex_is_load,
  input  logic [cpu_pkg::reg_addr_width-1:0] mem_dst,
  input  logic                               mem_reg_write,
  input  logic [cpu_pkg::reg_addr_width-1:0] wb_dst,
  input  logic                               wb_reg_write,
  input  logic                               branch_taken,
  output logic                               stall,
  output logic                               flush,
  output cpu_pkg::fwd_sel_t                  fwd_a,
  output cpu_pkg::fwd_sel_t                  fwd_b
);

  // younger write in ex/mem beats the one in mem/wb
  function automatic cpu_pkg::fwd_sel_t pick_fwd(
    input logic [cpu_pkg::reg_addr_width-1:0] src
  );
    cpu_pkg::fwd_sel_t sel;
    sel = cpu_pkg::fwd_none;
    if (src != '0) begin
      if (mem_reg_write && mem_dst == src) begin
        sel = cpu_pkg::fwd_ex_mem;
      end else if (wb_reg_write && wb_dst == src) begin
        sel = cpu_pkg::fwd_mem_wb;
      end
    end
    return sel;
  endfunction

  always_comb begin
    fwd_a = pick_fwd(ex_rs);
    fwd_b = pick_fwd(ex_rt);
  end

  // load in ex feeding the instruction in id
  always_comb begin
    stall = 1'b0;
    if (ex_is_load && ex_dst != '0 && (ex_dst == id_rs || ex_dst == id_rt)) begin
      stall = 1'b1;
    end
  end

  assign flush = branch_taken;

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
  parameter int addr_width = 16
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           stall,
  input  logic                           flush,
  input  logic                           branch_taken,
  input  logic [addr_width-1:0]          branch_target,
  output logic [addr_width-1:0]          instr_addr,
  input  logic [cpu_pkg::inst_width-1:0] instr,
  output logic [cpu_pkg::inst_width-1:0] if_id_instr
);

  logic [addr_width-1:0] pc;

  assign instr_addr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else if (!stall) begin
      pc <= pc + 1'b1;
    end
  end

  // if/id
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      if_id_instr <= {cpu_pkg::op_nop, {cpu_pkg::opcode_lsb{1'b0}}};
    end else if (!stall) begin
      if_id_instr <= instr;
    end
  end

endmodule

// File: hdl/decode_unit.sv
`timescale 1ns/1ps

module decode_unit #(
  parameter int data_width = 32
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               stall,
  input  logic                               flush,
  input  logic [cpu_pkg::inst_width-1:0]     if_id_instr,
  output logic [cpu_pkg::reg_addr_width-1:0] rd_addr_a,
  output logic [cpu_pkg::reg_addr_width-1:0] rd_addr_b,
  input  logic [data_width-1:0]              rd_data_a,
  input  logic [data_width-1:0]              rd_data_b,
  output logic [cpu_pkg::reg_addr_width-1:0] id_rs,
  output logic [cpu_pkg::reg_addr_width-1:0] id_rt,
  output cpu_pkg::opcode_t                   ex_op,
  output logic [data_width-1:0]              ex_a,
  output logic [data_width-1:0]              ex_b,
  output logic [cpu_pkg::imm_width-1:0]      ex_imm,
  output logic [cpu_pkg::reg_addr_width-1:0] ex_rs,
  output logic [cpu_pkg::reg_addr_width-1:0] ex_rt,
  output logic [cpu_pkg::reg_addr_width-1:0] ex_dst,
  output logic                               ex_reg_write,
  output logic                               ex_is_load
);

  logic [cpu_pkg::opcode_msb-cpu_pkg::opcode_lsb:0] op_field;
  logic [cpu_pkg::reg_addr_width-1:0]               rd;
  cpu_pkg::opcode_t                                 id_op;
  logic [cpu_pkg::reg_addr_width-1:0]               id_dst;
  logic                                             id_reg_write;

  assign op_field  = if_id_instr[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb];
  assign id_rs     = if_id_instr[cpu_pkg::rs_msb:cpu_pkg::rs_lsb];
  assign id_rt     = if_id_instr[cpu_pkg::rt_msb:cpu_pkg::rt_lsb];
  assign rd        = if_id_instr[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
  assign rd_addr_a = id_rs;
  assign rd_addr_b = id_rt;

  // unknown opcodes fall through as nop
  always_comb begin
    id_op        = cpu_pkg::op_nop;
    id_dst       = id_rt;
    id_reg_write = 1'b0;
    case (op_field)
      cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
      cpu_pkg::op_or, cpu_pkg::op_slt: begin
        id_op        = cpu_pkg::opcode_t'(op_field);
        id_dst       = rd;
        id_reg_write = 1'b1;
      end
      cpu_pkg::op_addi, cpu_pkg::op_lw: begin
        id_op        = cpu_pkg::opcode_t'(op_field);
        id_reg_write = 1'b1;
      end
      cpu_pkg::op_sw, cpu_pkg::op_beq, cpu_pkg::op_jmp: begin
        id_op = cpu_pkg::opcode_t'(op_field);
      end
      default: begin
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // id/ex
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || flush || stall) begin
      ex_op        <= cpu_pkg::op_nop;
      ex_rs        <= '0;
      ex_rt        <= '0;
      ex_dst       <= '0;
      ex_reg_write <= 1'b0;
      ex_is_load   <= 1'b0;
    end else begin
      ex_op        <= id_op;
      ex_rs        <= id_rs;
      ex_rt        <= id_rt;
      ex_dst       <= id_dst;
      ex_reg_write <= id_reg_write;
      ex_is_load   <= (id_op == cpu_pkg::op_lw);
    end
    ex_a   <= rd_data_a;
    ex_b   <= rd_data_b;
    ex_imm <= if_id_instr[cpu_pkg::imm_msb:cpu_pkg::imm_lsb];
  end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps

module register_file #(
  parameter int data_width = 32
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [cpu_pkg::reg_addr_width-1:0] rd_addr_a,
  input  logic [cpu_pkg::reg_addr_width-1:0] rd_addr_b,
  output logic [data_width-1:0]              rd_data_a,
  output logic [data_width-1:0]              rd_data_b,
  input  logic                               wr_en,
  input  logic [cpu_pkg::reg_addr_width-1:0] wr_addr,
  input  logic [data_width-1:0]              wr_data
);

  localparam int num_regs = 2 ** cpu_pkg::reg_addr_width;

  logic [data_width-1:0] regs [num_regs];
  logic                  wr_live;

  assign wr_live = wr_en && (wr_addr != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // same-cycle write shows through to the reads
  always_comb begin
    rd_data_a = (wr_live && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    rd_data_b = (wr_live && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];
  end

endmodule

// File: hdl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage #(
  parameter int data_width = 32,
  parameter int addr_width = 16
) (
  input  logic                               clk,
  input  logic                               reset,
  input  cpu_pkg::opcode_t                   mem_op,
  input  logic [data_width-1:0]              mem_alu,
  input  logic [data_width-1:0]              mem_store_data,
  input  logic [cpu_pkg::reg_addr_width-1:0] mem_dst,
  input  logic                               mem_reg_write,
  output logic [addr_width-1:0]              mem_addr,
  output logic [data_width-1:0]              mem_wdata,
  output logic                               mem_write,
  input  logic [data_width-1:0]              mem_rdata,
  output logic [cpu_pkg::reg_addr_width-1:0] wb_dst,
  output logic                               wb_reg_write,
  output logic [data_width-1:0]              wb_value
);

  logic                  wb_is_load;
  logic [data_width-1:0] wb_load_data;
  logic [data_width-1:0] wb_alu;

  // word address straight from the alu
  assign mem_addr  = mem_alu[addr_width-1:0];
  assign mem_wdata = mem_store_data;
  assign mem_write = (mem_op == cpu_pkg::op_sw);

  // mem/wb
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_dst       <= '0;
      wb_reg_write <= 1'b0;
      wb_is_load   <= 1'b0;
    end else begin
      wb_dst       <= mem_dst;
      wb_reg_write <= mem_reg_write;
      wb_is_load   <= (mem_op == cpu_pkg::op_lw);
    end
    wb_load_data <= mem_rdata;
    wb_alu       <= mem_alu;
  end

  assign wb_value = wb_is_load ? wb_load_data : wb_alu;

endmodule

// File: hdl/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
  parameter int data_width = 32,
  parameter int addr_width = 16
) (
  input  logic                           clk,
  input  logic                           reset,
  output logic [addr_width-1:0]          instr_addr,
  input  logic [cpu_pkg::inst_width-1:0] instr,
  output logic [addr_width-1:0]          mem_addr,
  output logic [data_width-1:0]          mem_wdata,
  output logic                           mem_write,
  input  logic [data_width-1:0]          mem_rdata
);

  localparam int rw = cpu_pkg::reg_addr_width;

  logic stall;
  logic flush;
  cpu_pkg::fwd_sel_t fwd_a;
  cpu_pkg::fwd_sel_t fwd_b;

  logic [cpu_pkg::inst_width-1:0] if_id_instr;

  logic [rw-1:0]          rd_addr_a;
  logic [rw-1:0]          rd_addr_b;
  logic [data_width-1:0]  rd_data_a;
  logic [data_width-1:0]  rd_data_b;
  logic [rw-1:0]          id_rs;
  logic [rw-1:0]          id_rt;

  // id/ex
  cpu_pkg::opcode_t              ex_op;
  logic [data_width-1:0]         ex_a;
  logic [data_width-1:0]         ex_b;
  logic [cpu_pkg::imm_width-1:0] ex_imm;
  logic [rw-1:0]                 ex_rs;
  logic [rw-1:0]                 ex_rt;
  logic [rw-1:0]                 ex_dst;
  logic                          ex_reg_write;
  logic                          ex_is_load;

  logic                  branch_taken;
  logic [addr_width-1:0] branch_target;

  // ex/mem
  cpu_pkg::opcode_t      mem_op;
  logic [data_width-1:0] mem_alu;
  logic [data_width-1:0] mem_store_data;
  logic [rw-1:0]         mem_dst;
  logic                  mem_reg_write;

  // mem/wb
  logic [rw-1:0]         wb_dst;
  logic                  wb_reg_write;
  logic [data_width-1:0] wb_value;

  pipeline_control pipeline_control_inst (
    .id_rs(id_rs), .id_rt(id_rt),
    .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_dst(ex_dst), .ex_is_load(ex_is_load),
    .mem_dst(mem_dst), .mem_reg_write(mem_reg_write),
    .wb_dst(wb_dst), .wb_reg_write(wb_reg_write),
    .branch_taken(branch_taken),
    .stall(stall), .flush(flush), .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  fetch_unit #(.addr_width(addr_width)) fetch_unit_inst (
    .clk(clk), .reset(reset), .stall(stall), .flush(flush),
    .branch_taken(branch_taken), .branch_target(branch_target),
    .instr_addr(instr_addr), .instr(instr), .if_id_instr(if_id_instr)
  );

  decode_unit #(.data_width(data_width)) decode_unit_inst (
    .clk(clk), .reset(reset), .stall(stall), .flush(flush),
    .if_id_instr(if_id_instr),
    .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
    .id_rs(id_rs), .id_rt(id_rt),
    .ex_op(ex_op), .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
    .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_dst(ex_dst),
    .ex_reg_write(ex_reg_write), .ex_is_load(ex_is_load)
  );

  register_file #(.data_width(data_width)) register_file_inst (
    .clk(clk), .reset(reset),
    .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
    .wr_en(wb_reg_write), .wr_addr(wb_dst), .wr_data(wb_value)
  );

  execute_unit #(.data_width(data_width), .addr_width(addr_width)) execute_unit_inst (
    .clk(clk), .reset(reset),
    .ex_op(ex_op), .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm),
    .ex_dst(ex_dst), .ex_reg_write(ex_reg_write),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .wb_value(wb_value),
    .branch_taken(branch_taken), .branch_target(branch_target),
    .mem_op(mem_op), .mem_alu(mem_alu), .mem_store_data(mem_store_data),
    .mem_dst(mem_dst), .mem_reg_write(mem_reg_write)
  );

  memory_stage #(.data_width(data_width), .addr_width(addr_width)) memory_stage_inst (
    .clk(clk), .reset(reset),
    .mem_op(mem_op), .mem_alu(mem_alu), .mem_store_data(mem_store_data),
    .mem_dst(mem_dst), .mem_reg_write(mem_reg_write),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_write(mem_write),
    .mem_rdata(mem_rdata),
    .wb_dst(wb_dst), .wb_reg_write(wb_reg_write), .wb_value(wb_value)
  );

endmodule

// File: tb/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
  parameter int period_ns    = 100,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2) clk = ~clk;
    end
  end

  // power-on reset released just after an edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

// File: tb/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb;

  localparam int data_width      = 32;
  localparam int addr_width      = 16;
  localparam int period_ns       = 100;
  localparam int reset_cycles    = 8;
  localparam int num_tests       = 6;
  localparam int cycles_per_test = 300;
  localparam int instr_depth     = 256;
  localparam int data_depth      = 2 ** addr_width;
  localparam longint watchdog_ns =
    longint'(num_tests * cycles_per_test + (num_tests + 1) * reset_cycles) * period_ns;

  logic                  clk;
  logic                  por_reset;
  logic                  test_reset;
  logic                  reset;
  logic [addr_width-1:0] instr_addr;
  logic [31:0]           instr;
  logic [addr_width-1:0] mem_addr;
  logic [data_width-1:0] mem_wdata;
  logic                  mem_write;
  logic [data_width-1:0] mem_rdata;

  logic [31:0]           instr_mem [instr_depth];
  logic [data_width-1:0] data_mem [data_depth];

  // architectural state as the instruction rules see it
  logic [data_width-1:0] model_regs [32];
  logic [data_width-1:0] model_mem [int];
  int                    prog_len;
  int                    skip_count;
  int                    halt_addr;

  logic [addr_width-1:0] exp_addr [$];
  logic [data_width-1:0] exp_data [$];
  logic [addr_width-1:0] got_addr [$];
  logic [data_width-1:0] got_data [$];
  longint                got_time [$];

  logic [15:0] lfsr_state;
  int          test_errors;
  int          total_errors;
  int          checks;
  int          tests_run;
  int          tests_failed;

  clock_gen #(.period_ns(period_ns), .reset_cycles(reset_cycles)) clock_gen_inst (
    .clk(clk),
    .reset(por_reset)
  );

  assign reset = por_reset || test_reset;

  cpu_core #(.data_width(data_width), .addr_width(addr_width)) cpu_core_inst (
    .clk(clk), .reset(reset),
    .instr_addr(instr_addr), .instr(instr),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_write(mem_write),
    .mem_rdata(mem_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // memory models
  //////////////////////////////////////////////////////////////////////

  assign instr     = instr_mem[instr_addr[$clog2(instr_depth)-1:0]];
  assign mem_rdata = data_mem[mem_addr];

  always @(posedge clk) begin
    if (!reset && mem_write) begin
      data_mem[mem_addr] <= mem_wdata;
      got_addr.push_back(mem_addr);
      got_data.push_back(mem_wdata);
      got_time.push_back($time);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // rules, encoding and random numbers
  //////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [data_width-1:0] fill_word(input logic [addr_width-1:0] a);
    return {a ^ 16'hc3a5, a};
  endfunction

  function automatic logic [data_width-1:0] alu_rule(input cpu_pkg::opcode_t op,
                                                     input logic [data_width-1:0] a,
                                                     input logic [data_width-1:0] b);
    case (op)
      cpu_pkg::op_add: return a + b;
      cpu_pkg::op_sub: return a - b;
      cpu_pkg::op_and: return a & b;
      cpu_pkg::op_or:  return a | b;
      cpu_pkg::op_slt: return ($signed(a) < $signed(b)) ? data_width'(1) : '0;
      default:         return '0;
    endcase
  endfunction

  function automatic logic [31:0] r_word(input cpu_pkg::opcode_t op, input int rs,
                                         input int rt, input int rd);
    logic [31:0] w;
    w = '0;
    w[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb] = op;
    w[cpu_pkg::rs_msb:cpu_pkg::rs_lsb] = 5'(rs);
    w[cpu_pkg::rt_msb:cpu_pkg::rt_lsb] = 5'(rt);
    w[cpu_pkg::rd_msb:cpu_pkg::rd_lsb] = 5'(rd);
    return w;
  endfunction

  function automatic logic [31:0] i_word(input cpu_pkg::opcode_t op, input int rs,
                                         input int rt, input logic [15:0] imm);
    logic [31:0] w;
    w = '0;
    w[cpu_pkg::opcode_msb:cpu_pkg::opcode_lsb] = op;
    w[cpu_pkg::rs_msb:cpu_pkg::rs_lsb] = 5'(rs);
    w[cpu_pkg::rt_msb:cpu_pkg::rt_lsb] = 5'(rt);
    w[cpu_pkg::imm_msb:cpu_pkg::imm_lsb] = imm;
    return w;
  endfunction

  // false while the word sits in the shadow of a taken branch or jump
  function automatic bit place(input logic [31:0] w);
    bit live;
    instr_mem[prog_len] = w;
    prog_len++;
    live = (skip_count == 0);
    if (!live) begin
      skip_count--;
    end
    return live;
  endfunction

  function automatic void set_reg(input int r, input logic [data_width-1:0] v);
    if (r != 0) begin
      model_regs[r] = v;
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // program building
  //////////////////////////////////////////////////////////////////////

  task automatic alu_instr(input cpu_pkg::opcode_t op, input int rd, input int rs, input int rt);
    if (place(r_word(op, rs, rt, rd))) begin
      set_reg(rd, alu_rule(op, model_regs[rs], model_regs[rt]));
    end
  endtask

  task automatic addi_instr(input int rt, input int rs, input logic [15:0] imm);
    if (place(i_word(cpu_pkg::op_addi, rs, rt, imm))) begin
      set_reg(rt, model_regs[rs] + data_width'(imm));
    end
  endtask

  task automatic load_word(input int rt, input int rs, input logic [15:0] imm);
    logic [addr_width-1:0] a;
    a = addr_width'(model_regs[rs] + data_width'(imm));
    if (place(i_word(cpu_pkg::op_lw, rs, rt, imm))) begin
      set_reg(rt, model_mem.exists(a) ? model_mem[a] : fill_word(a));
    end
  endtask

  task automatic store_word(input int rt, input int rs, input logic [15:0] imm);
    logic [addr_width-1:0] a;
    a = addr_width'(model_regs[rs] + data_width'(imm));
    if (place(i_word(cpu_pkg::op_sw, rs, rt, imm))) begin
      model_mem[a] = model_regs[rt];
      exp_addr.push_back(a);
      exp_data.push_back(model_regs[rt]);
    end
  endtask

  // target lies just past the two wrong-path slots
  task automatic branch_eq(input int rs, input int rt);
    bit taken;
    taken = (model_regs[rs] == model_regs[rt]);
    if (place(i_word(cpu_pkg::op_beq, rs, rt, 16'(prog_len + 3)))) begin
      skip_count = taken ? 2 : 0;
    end
  endtask

  task automatic jump_over_two();
    if (place(i_word(cpu_pkg::op_jmp, 0, 0, 16'(prog_len + 3)))) begin
      skip_count = 2;
    end
  endtask

  task automatic halt_loop();
    halt_addr = prog_len;
    void'(place(i_word(cpu_pkg::op_jmp, 0, 0, 16'(prog_len))));
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequencing and checking
  //////////////////////////////////////////////////////////////////////

  task automatic clear_state();
    for (int i = 0; i < instr_depth; i++) begin
      instr_mem[i] = '0;
    end
    for (int i = 0; i < data_depth; i++) begin
      data_mem[i] = fill_word(addr_width'(i));
    end
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    model_mem.delete();
    exp_addr.delete();
    exp_data.delete();
    got_addr.delete();
    got_data.delete();
    got_time.delete();
    prog_len    = 0;
    skip_count  = 0;
    halt_addr   = 0;
    test_errors = 0;
  endtask

  task automatic begin_test();
    @(posedge clk);
    #1;
    test_reset = 1'b1;
    clear_state();
  endtask

  task automatic compare_stores();
    int n;
    n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
    assert (got_addr.size() == exp_addr.size()) else begin
      $display("store count wrong: %0d stores seen, %0d expected",
               got_addr.size(), exp_addr.size());
      test_errors++;
    end
    for (int i = 0; i < n; i++) begin
      checks++;
      assert (got_addr[i] == exp_addr[i]) else begin
        $display("FAILED at %0d ns: mem_addr of store %0d expected %h got %h",
                 got_time[i], i, exp_addr[i], got_addr[i]);
        test_errors++;
      end
      assert (got_data[i] == exp_data[i]) else begin
        $display("FAILED at %0d ns: mem_wdata of store %0d expected %h got %h",
                 got_time[i], i, exp_data[i], got_data[i]);
        test_errors++;
      end
    end
  endtask

  task automatic run_program(input string name);
    int hits;
    int cycles;
    hits   = 0;
    cycles = 0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    test_reset = 1'b0;
    // by the third fetch of the halt jump every store has left MEM
    while (hits < 3 && cycles < cycles_per_test) begin
      @(negedge clk);
      cycles++;
      if (instr_addr == addr_width'(halt_addr)) begin
        hits++;
      end
    end
    assert (hits == 3) else begin
      $display("test %s: program never settled in its halt loop", name);
      test_errors++;
    end
    compare_stores();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("test %-16s ok, %0d stores checked", name, exp_addr.size());
    end else begin
      tests_failed++;
      $display("test %-16s %0d errors", name, test_errors);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic forward_alu_chain();
    begin_test();
    addi_instr(1, 0, 16'd100);
    addi_instr(2, 0, 16'd7);
    alu_instr(cpu_pkg::op_add, 3, 1, 2);
    store_word(3, 0, 16'd16);
    alu_instr(cpu_pkg::op_sub, 4, 3, 1);
    store_word(4, 0, 16'd17);
    alu_instr(cpu_pkg::op_and, 5, 4, 3);
    alu_instr(cpu_pkg::op_or, 6, 5, 2);
    store_word(5, 0, 16'd18);
    store_word(6, 0, 16'd19);
    alu_instr(cpu_pkg::op_sub, 7, 2, 1);
    alu_instr(cpu_pkg::op_slt, 8, 7, 2);
    alu_instr(cpu_pkg::op_slt, 9, 1, 7);
    store_word(7, 0, 16'd20);
    store_word(8, 0, 16'd21);
    store_word(9, 0, 16'd22);
    halt_loop();
    run_program("alu_forwarding");
  endtask

  task automatic load_use_stall();
    begin_test();
    addi_instr(1, 0, 16'h1234);
    store_word(1, 0, 16'd32);
    load_word(2, 0, 16'd32);
    alu_instr(cpu_pkg::op_add, 3, 2, 1);
    store_word(3, 0, 16'd33);
    load_word(4, 0, 16'd200);
    alu_instr(cpu_pkg::op_sub, 5, 1, 4);
    store_word(5, 0, 16'd34);
    load_word(6, 0, 16'd201);
    store_word(6, 0, 16'd35);
    halt_loop();
    run_program("load_use");
  endtask

  task automatic branch_flush();
    begin_test();
    addi_instr(1, 0, 16'd5);
    addi_instr(2, 0, 16'd5);
    addi_instr(3, 0, 16'd9);
    branch_eq(1, 2);
    store_word(1, 0, 16'd40);
    store_word(2, 0, 16'd41);
    store_word(3, 0, 16'd42);
    branch_eq(1, 3);
    store_word(1, 0, 16'd43);
    store_word(3, 0, 16'd44);
    addi_instr(4, 0, 16'd9);
    branch_eq(4, 3);
    store_word(4, 0, 16'd45);
    addi_instr(4, 0, 16'd1);
    store_word(4, 0, 16'd46);
    halt_loop();
    run_program("branches");
  endtask

  task automatic jump_skip();
    begin_test();
    addi_instr(1, 0, 16'd77);
    jump_over_two();
    store_word(1, 0, 16'd50);
    store_word(1, 0, 16'd51);
    store_word(1, 0, 16'd52);
    addi_instr(2, 1, 16'd3);
    jump_over_two();
    addi_instr(2, 0, 16'd0);
    store_word(2, 0, 16'd53);
    store_word(2, 0, 16'd54);
    halt_loop();
    run_program("jump");
  endtask

  task automatic zero_register();
    begin_test();
    addi_instr(0, 0, 16'h7fff);
    store_word(0, 0, 16'd60);
    addi_instr(1, 0, 16'd3);
    alu_instr(cpu_pkg::op_add, 0, 1, 1);
    store_word(0, 0, 16'd61);
    alu_instr(cpu_pkg::op_add, 2, 0, 1);
    store_word(2, 0, 16'd62);
    halt_loop();
    run_program("register_zero");
  endtask

  task automatic random_operands();
    cpu_pkg::opcode_t ops [5];
    int rs;
    int rt;
    ops = '{cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and, cpu_pkg::op_or,
            cpu_pkg::op_slt};
    begin_test();
    for (int r = 1; r <= 4; r++) begin
      addi_instr(r, 0, 16'(random_bits(16)));
    end
    for (int j = 0; j < 8; j++) begin
      rs = 1 + int'(random_bits(2));
      rt = (j == 0) ? 1 + int'(random_bits(2)) : 9 + j;
      alu_instr(ops[random_bits(3) % 5], 10 + j, rs, rt);
      store_word(10 + j, 0, 16'(64 + j));
    end
    halt_loop();
    run_program("random_operands");
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    test_reset   = 1'b0;
    lfsr_state   = 16'd45182;
    total_errors = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    clear_state();
    wait (!por_reset);
    forward_alu_chain();
    load_use_stall();
    branch_flush();
    jump_skip();
    zero_register();
    random_operands();
    $display("tests %0d, failing tests %0d, store checks %0d, errors %0d",
             tests_run, tests_failed, checks, total_errors);
    if (total_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: sim.f
common/cpu_pkg.sv
execute/alu.sv
execute/execute_unit.sv
hdl/pipeline_control.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/memory_stage.sv
hdl/cpu_core.sv
tb/clock_gen.sv
tb/cpu_core_tb.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - common/cpu_pkg.sv
  - execute/alu.sv
  - execute/execute_unit.sv
  - hdl/pipeline_control.sv
  - hdl/fetch_unit.sv
  - hdl/decode_unit.sv
  - hdl/register_file.sv
  - hdl/memory_stage.sv
  - hdl/cpu_core.sv
  - target: simulation
    files:
      - tb/clock_gen.sv
      - tb/cpu_core_tb.sv
